// ==== src/periph_pkg.sv ====
// ----------------------------------------------------------
// Peripheral subsystem shared definitions
// Bus widths, address layout, register map and the marker
// value returned on errors and undefined registers
// ----------------------------------------------------------
`default_nettype none

package periph_pkg;

   localparam int DataWidth   = 32;
   localparam int AddrWidth   = 32;
   localparam int RegionWidth = 4;
   localparam int IndexWidth  = 10;

   // Bus address, seen as a raw word or as decode fields
   typedef union packed {
      logic [AddrWidth-1:0] raw;
      struct packed {
         logic [15:0]            unused; // Bits 31:16
         logic [RegionWidth-1:0] region; // Bits 15:12
         logic [IndexWidth-1:0]  index;  // Word index
         logic [1:0]             offset; // Byte offset
      } fields;
   } periph_addr_t;

   // Region codes, all others unmapped
   localparam logic [RegionWidth-1:0] RegionPlic = 4'd0;
   localparam logic [RegionWidth-1:0] RegionGpio = 4'd1;

   // Interrupt controller register map
   localparam logic [IndexWidth-1:0] PlicPrioBase      = 10'd0;   // Index 0 reserved
   localparam logic [IndexWidth-1:0] PlicPendingIdx    = 10'd64;
   localparam logic [IndexWidth-1:0] PlicEnableBase    = 10'd128; // Plus target
   localparam logic [IndexWidth-1:0] PlicThresholdBase = 10'd192; // Plus target
   localparam logic [IndexWidth-1:0] PlicClaimBase     = 10'd256; // Plus target

   // GPIO register map
   localparam logic [IndexWidth-1:0] GpioLedIdx    = 10'd0;
   localparam logic [IndexWidth-1:0] GpioSwitchIdx = 10'd1;

   localparam logic [DataWidth-1:0] ErrorRdata = 32'hDEADBEEF;

endpackage

`default_nettype wire

// ==== src/periph_addr_decode.sv ====
// ----------------------------------------------------------
// Register bus address decoder
// Selects one target per request by region, flags unmapped
// accesses and returns the response one cycle later
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_addr_decode (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            req_i,
   input  logic                            we_i,
   input  periph_pkg::periph_addr_t        addr_i,
   output logic                            plic_sel_o,
   output logic                            gpio_sel_o,
   input  logic [periph_pkg::DataWidth-1:0] plic_rdata_i,
   input  logic [periph_pkg::DataWidth-1:0] gpio_rdata_i,
   output logic                            rsp_valid_o,
   output logic [periph_pkg::DataWidth-1:0] rdata_o,
   output logic                            err_o
);
   import periph_pkg::*;

   logic                   unmapped;
   logic                   rsp_valid_q;
   logic                   err_q;
   logic                   we_q;
   logic [RegionWidth-1:0] region_q;

   assign plic_sel_o = req_i && (addr_i.fields.region == RegionPlic);
   assign gpio_sel_o = req_i && (addr_i.fields.region == RegionGpio);
   assign unmapped   = !(addr_i.fields.region inside {RegionPlic, RegionGpio});

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rsp_valid_q <= 1'b0;
         err_q       <= 1'b0;
      end else begin
         rsp_valid_q <= req_i;
         err_q       <= req_i && unmapped;
      end
   end

   // Response side info, only meaningful with rsp_valid_q
   always_ff @(posedge clk_i) begin
      if (req_i) begin
         we_q     <= we_i;
         region_q <= addr_i.fields.region;
      end
   end

   // ----------------------------------------------------------
   // Response mux
   // ----------------------------------------------------------
   always_comb begin
      rdata_o = '0;
      if (rsp_valid_q && !we_q) begin
         if (err_q)                        rdata_o = ErrorRdata;
         else if (region_q == RegionPlic)  rdata_o = plic_rdata_i;
         else                              rdata_o = gpio_rdata_i;
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign err_o       = err_q;

endmodule

`default_nettype wire

// ==== src/periph_gpio.sv ====
// ----------------------------------------------------------
// LED / DIP switch GPIO
// One writable LED register and a read-only switch register
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_gpio #(
   parameter int LedWidth = 8
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             sel_i,
   input  logic                             we_i,
   input  logic [periph_pkg::IndexWidth-1:0] index_i,
   input  logic [periph_pkg::DataWidth-1:0]  wdata_i,
   input  logic [LedWidth-1:0]               dip_switches_i,
   output logic [periph_pkg::DataWidth-1:0]  rdata_o,
   output logic [LedWidth-1:0]               leds_o
);
   import periph_pkg::*;

   // LED register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         leds_o <= '0;
      end else if (sel_i && we_i && (index_i == GpioLedIdx)) begin
         leds_o <= wdata_i[LedWidth-1:0];
      end
   end

   // Read data, picked up by the decoder next cycle
   always_ff @(posedge clk_i) begin
      if (sel_i && !we_i) begin
         case (index_i)
            GpioLedIdx:    rdata_o <= DataWidth'(leds_o);
            GpioSwitchIdx: rdata_o <= DataWidth'(dip_switches_i); // Raw, no sync
            default:       rdata_o <= ErrorRdata;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/periph_plic.sv ====
// ----------------------------------------------------------
// Platform-level interrupt controller
// Level gateways, pending bits, per-source priorities,
// per-target enables and thresholds, claim/complete
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_plic #(
   parameter int NumSources = 8,
   parameter int NumTargets = 2,
   parameter int PrioWidth  = 3
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             sel_i,
   input  logic                             we_i,
   input  logic [periph_pkg::IndexWidth-1:0] index_i,
   input  logic [periph_pkg::DataWidth-1:0]  wdata_i,
   input  logic [NumSources-1:0]             irq_sources_i,
   output logic [periph_pkg::DataWidth-1:0]  rdata_o,
   output logic [NumTargets-1:0]             irq_o
);
   import periph_pkg::*;

   localparam int IdWidth = $clog2(NumSources + 1);

   // Sources are numbered from 1, ID 0 means none
   logic [NumSources:1]  src_level;
   logic [NumSources:1]  pending_q;
   logic [NumSources:1]  claimed_q;   // Gateway closed until complete
   logic [NumSources:1]  claim_set;
   logic [NumSources:1]  complete_clr;
   logic [PrioWidth-1:0] prio_q      [NumSources:1];
   logic [NumSources:1]  enable_q    [NumTargets];
   logic [PrioWidth-1:0] threshold_q [NumTargets];
   logic [IdWidth-1:0]   best_id     [NumTargets];
   logic [PrioWidth-1:0] best_prio   [NumTargets];
   logic [DataWidth-1:0] rdata_d;

   assign src_level = irq_sources_i; // Bit 0 is source 1

   // ----------------------------------------------------------
   // Per-target arbitration
   // ----------------------------------------------------------
   always_comb begin
      for (int t = 0; t < NumTargets; t++) begin
         best_id[t]   = '0;
         best_prio[t] = '0;
         for (int s = 1; s <= NumSources; s++) begin
            // Strict compare keeps the lowest ID on a tie
            if (pending_q[s] && enable_q[t][s] && (prio_q[s] > threshold_q[t])
                && (prio_q[s] > best_prio[t])) begin
               best_id[t]   = IdWidth'(s);
               best_prio[t] = prio_q[s];
            end
         end
         irq_o[t] = (best_id[t] != '0);
      end
   end

   // Claim reads and complete writes
   always_comb begin
      claim_set    = '0;
      complete_clr = '0;
      for (int t = 0; t < NumTargets; t++) begin
         for (int s = 1; s <= NumSources; s++) begin
            if (sel_i && (index_i == PlicClaimBase + IndexWidth'(t))) begin
               if (!we_i && (best_id[t] == IdWidth'(s))) claim_set[s] = 1'b1;
               if (we_i && (wdata_i == DataWidth'(s)))   complete_clr[s] = 1'b1;
            end
         end
      end
   end

   // ----------------------------------------------------------
   // Register read mux
   // ----------------------------------------------------------
   always_comb begin
      rdata_d = ErrorRdata;
      for (int s = 1; s <= NumSources; s++) begin
         if (index_i == PlicPrioBase + IndexWidth'(s)) rdata_d = DataWidth'(prio_q[s]);
      end
      if (index_i == PlicPendingIdx) rdata_d = DataWidth'({pending_q, 1'b0});
      for (int t = 0; t < NumTargets; t++) begin
         if (index_i == PlicEnableBase + IndexWidth'(t)) begin
            rdata_d = DataWidth'({enable_q[t], 1'b0});
         end
         if (index_i == PlicThresholdBase + IndexWidth'(t)) begin
            rdata_d = DataWidth'(threshold_q[t]);
         end
         if (index_i == PlicClaimBase + IndexWidth'(t)) rdata_d = DataWidth'(best_id[t]);
      end
   end

   always_ff @(posedge clk_i) begin
      if (sel_i && !we_i) rdata_o <= rdata_d;
   end

   // ----------------------------------------------------------
   // State update
   // ----------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pending_q <= '0;
         claimed_q <= '0;
         for (int s = 1; s <= NumSources; s++) prio_q[s] <= '0;
         for (int t = 0; t < NumTargets; t++) begin
            enable_q[t]    <= '0;
            threshold_q[t] <= '0;
         end
      end else begin
         // Claim clear wins over a new gateway request
         pending_q <= (pending_q | (src_level & ~claimed_q)) & ~claim_set;
         claimed_q <= (claimed_q | claim_set) & ~complete_clr;
         if (sel_i && we_i) begin
            for (int s = 1; s <= NumSources; s++) begin
               if (index_i == PlicPrioBase + IndexWidth'(s)) prio_q[s] <= wdata_i[PrioWidth-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
               if (index_i == PlicEnableBase + IndexWidth'(t)) begin
                  enable_q[t] <= wdata_i[NumSources:1]; // Bit 0 ignored
               end
               if (index_i == PlicThresholdBase + IndexWidth'(t)) begin
                  threshold_q[t] <= wdata_i[PrioWidth-1:0];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/periph_subsys.sv ====
// ----------------------------------------------------------
// Peripheral subsystem top level
// Register bus decoder with the interrupt controller and
// the LED / DIP switch GPIO behind it
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_subsys #(
   parameter int NumSources = 8,
   parameter int NumTargets = 2,
   parameter int PrioWidth  = 3,
   parameter int LedWidth   = 8
) (
   input  logic                            clk_i,
   input  logic                            reset_i,
   // Register bus
   input  logic                            req_i,
   input  logic                            we_i,
   input  periph_pkg::periph_addr_t        addr_i,
   input  logic [periph_pkg::DataWidth-1:0] wdata_i,
   output logic                            rsp_valid_o,
   output logic [periph_pkg::DataWidth-1:0] rdata_o,
   output logic                            err_o,
   // Interrupts
   input  logic [NumSources-1:0]            irq_sources_i,
   output logic [NumTargets-1:0]            irq_o,
   // Board IO
   input  logic [LedWidth-1:0]              dip_switches_i,
   output logic [LedWidth-1:0]              leds_o
);
   import periph_pkg::*;

   logic                 plic_sel;
   logic                 gpio_sel;
   logic [DataWidth-1:0] plic_rdata;
   logic [DataWidth-1:0] gpio_rdata;

   periph_addr_decode i_addr_decode (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (req_i),
      .we_i         (we_i),
      .addr_i       (addr_i),
      .plic_sel_o   (plic_sel),
      .gpio_sel_o   (gpio_sel),
      .plic_rdata_i (plic_rdata),
      .gpio_rdata_i (gpio_rdata),
      .rsp_valid_o  (rsp_valid_o),
      .rdata_o      (rdata_o),
      .err_o        (err_o)
   );

   periph_gpio #(.LedWidth(LedWidth)) i_gpio (
      .clk_i (clk_i), .reset_i (reset_i), .sel_i (gpio_sel), .we_i (we_i),
      .index_i (addr_i.fields.index), .wdata_i (wdata_i),
      .dip_switches_i (dip_switches_i), .rdata_o (gpio_rdata), .leds_o (leds_o)
   );

   periph_plic #(
      .NumSources (NumSources), .NumTargets (NumTargets), .PrioWidth (PrioWidth)
   ) i_plic (
      .clk_i (clk_i), .reset_i (reset_i), .sel_i (plic_sel), .we_i (we_i),
      .index_i (addr_i.fields.index), .wdata_i (wdata_i),
      .irq_sources_i (irq_sources_i), .rdata_o (plic_rdata), .irq_o (irq_o)
   );

endmodule

`default_nettype wire

// ==== tb/periph_subsys_assertions.sv ====
// ----------------------------------------------------------
// Peripheral subsystem bus and reset checker
// Bound to the top level to watch response timing and the
// state right after reset
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_subsys_assertions #(
   parameter int NumTargets = 2
) (
   input logic                  clk_i,
   input logic                  reset_i,
   input logic                  req_i,
   input logic                  rsp_valid_o,
   input logic                  err_o,
   input logic [NumTargets-1:0] irq_o
);

   int fail_count = 0;

   // Requests seen during reset get no response
   rsp_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_o == $past(req_i && !reset_i))
      else begin
         $error("rsp_valid_o does not follow req_i by one cycle");
         fail_count++;
      end

   err_with_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
      err_o |-> rsp_valid_o)
      else begin
         $error("err_o high without rsp_valid_o");
         fail_count++;
      end

   rsp_low_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !rsp_valid_o)
      else begin
         $error("rsp_valid_o high right after reset");
         fail_count++;
      end

   irq_low_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> (irq_o == '0))
      else begin
         $error("irq_o high right after reset");
         fail_count++;
      end

endmodule

bind periph_subsys periph_subsys_assertions #(.NumTargets(NumTargets)) i_assertions (
   .clk_i (clk_i), .reset_i (reset_i), .req_i (req_i),
   .rsp_valid_o (rsp_valid_o), .err_o (err_o), .irq_o (irq_o)
);

`default_nettype wire

// ==== tb/tb_periph_subsys.sv ====
// ----------------------------------------------------------
// Peripheral subsystem testbench
// Directed tests of GPIO, unmapped accesses, interrupt
// priority, claim/complete and back-to-back bus requests
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_periph_subsys;
   import periph_pkg::*;

   logic         clk_i = 1'b0;
   logic         reset_i;
   logic         req_i;
   logic         we_i;
   periph_addr_t addr_i;
   logic [31:0]  wdata_i;
   logic         rsp_valid_o;
   logic [31:0]  rdata_o;
   logic         err_o;
   logic [7:0]   irq_sources_i;
   logic [1:0]   irq_o;
   logic [7:0]   dip_switches_i;
   logic [7:0]   leds_o;

   integer       seed = 42058;
   int           value_errors = 0;
   int           timeouts = 0;
   logic [7:0]   led_shadow = 8'h00; // Last value written to the LEDs

   periph_subsys #(
      .NumSources (8), .NumTargets (2), .PrioWidth (3), .LedWidth (8)
   ) periph_subsys_i (
      .clk_i (clk_i), .reset_i (reset_i), .req_i (req_i), .we_i (we_i),
      .addr_i (addr_i), .wdata_i (wdata_i), .rsp_valid_o (rsp_valid_o),
      .rdata_o (rdata_o), .err_o (err_o), .irq_sources_i (irq_sources_i),
      .irq_o (irq_o), .dip_switches_i (dip_switches_i), .leds_o (leds_o)
   );

   always #2 clk_i = ~clk_i;

   function automatic periph_addr_t make_addr(input logic [3:0] region,
                                              input logic [9:0] index);
      periph_addr_t a;
      a.raw          = '0;
      a.fields.region = region;
      a.fields.index  = index;
      return a;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      value_errors++;
   endtask

   // Starts on a falling edge and ends on the one after the response
   task automatic bus_access(input logic we, input periph_addr_t addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int cycles;
      req_i   = 1'b1;
      we_i    = we;
      addr_i  = addr;
      wdata_i = wdata;
      @(negedge clk_i);
      req_i  = 1'b0;
      cycles = 0;
      while (!rsp_valid_o && cycles < 10) begin
         @(negedge clk_i);
         cycles++;
      end
      if (!rsp_valid_o) begin
         $display("Timeout at %0t ns: no bus response to address %h", $time, addr.raw);
         timeouts++;
      end
      rdata = rdata_o;
      err   = err_o;
   endtask

   task automatic bus_write(input logic [3:0] region, input logic [9:0] index,
                            input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b1, make_addr(region, index), data, rdata, err);
      if (err !== exp_err) report_mismatch("err_o", err, exp_err);
   endtask

   task automatic bus_read_check(input logic [3:0] region, input logic [9:0] index,
                                 input logic [31:0] exp_data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b0, make_addr(region, index), 32'h0, rdata, err);
      if (rdata !== exp_data) report_mismatch("rdata_o", rdata, exp_data);
      if (err !== exp_err) report_mismatch("err_o", err, exp_err);
   endtask

   task automatic wait_irq(input int target, input logic level);
      int cycles;
      cycles = 0;
      while (irq_o[target] !== level && cycles < 50) begin
         @(negedge clk_i);
         cycles++;
      end
      if (irq_o[target] !== level) begin
         $display("Timeout at %0t ns: irq_o[%0d] never went to %0b", $time, target, level);
         timeouts++;
      end
   endtask

   // ----------------------------------------------------------
   // Tests
   // ----------------------------------------------------------
   task automatic reset_state();
      if (irq_o !== 2'b00) report_mismatch("irq_o", irq_o, 0);
      if (leds_o !== 8'h00) report_mismatch("leds_o", leds_o, 0);
      for (int t = 0; t < 2; t++) begin
         bus_read_check(RegionPlic, PlicEnableBase + t, 32'h0, 1'b0);
         bus_read_check(RegionPlic, PlicThresholdBase + t, 32'h0, 1'b0);
      end
   endtask

   task automatic gpio_access();
      logic [31:0] val;
      for (int i = 0; i < 4; i++) begin
         val = $random(seed);
         bus_write(RegionGpio, GpioLedIdx, val, 1'b0);
         led_shadow = val[7:0];
         if (leds_o !== led_shadow) report_mismatch("leds_o", leds_o, led_shadow);
         bus_read_check(RegionGpio, GpioLedIdx, {24'h0, led_shadow}, 1'b0);
      end
      dip_switches_i = $random(seed);
      bus_read_check(RegionGpio, GpioSwitchIdx, {24'h0, dip_switches_i}, 1'b0);
      bus_read_check(RegionGpio, 10'd2, ErrorRdata, 1'b0); // Undefined index
   endtask

   task automatic unmapped_access();
      bus_read_check(4'd5, 10'd0, ErrorRdata, 1'b1);
      bus_write(4'd5, 10'd0, {24'h0, ~led_shadow}, 1'b1);
      if (leds_o !== led_shadow) report_mismatch("leds_o", leds_o, led_shadow);
      bus_read_check(RegionGpio, GpioLedIdx, {24'h0, led_shadow}, 1'b0);
   endtask

   task automatic priority_threshold();
      bus_write(RegionPlic, PlicPrioBase + 2, 32'd3, 1'b0);
      bus_write(RegionPlic, PlicPrioBase + 5, 32'd6, 1'b0);
      bus_write(RegionPlic, PlicEnableBase + 0, 32'h24, 1'b0); // Sources 2 and 5
      bus_write(RegionPlic, PlicThresholdBase + 0, 32'd0, 1'b0);
      if (irq_o !== 2'b00) report_mismatch("irq_o", irq_o, 0);
      irq_sources_i = 8'b0001_0010;
      wait_irq(0, 1'b1);
      if (irq_o[1] !== 1'b0) report_mismatch("irq_o[1]", irq_o[1], 0);
      bus_read_check(RegionPlic, PlicPendingIdx, 32'h24, 1'b0);
      bus_read_check(RegionPlic, PlicClaimBase + 0, 32'd5, 1'b0);
      bus_write(RegionPlic, PlicThresholdBase + 0, 32'd3, 1'b0); // Equal to source 2
      wait_irq(0, 1'b0);
   endtask

   task automatic claim_complete();
      repeat (4) @(negedge clk_i); // Source 5 stays high while claimed
      bus_read_check(RegionPlic, PlicPendingIdx, 32'h04, 1'b0);
      bus_write(RegionPlic, PlicThresholdBase + 0, 32'd0, 1'b0);
      bus_read_check(RegionPlic, PlicClaimBase + 0, 32'd2, 1'b0);
      irq_sources_i = 8'b0001_0000;
      bus_read_check(RegionPlic, PlicClaimBase + 0, 32'd0, 1'b0);
      if (irq_o[0] !== 1'b0) report_mismatch("irq_o[0]", irq_o[0], 0);
      bus_write(RegionPlic, PlicClaimBase + 0, 32'd5, 1'b0);
      wait_irq(0, 1'b1);
      bus_read_check(RegionPlic, PlicPendingIdx, 32'h20, 1'b0);
      bus_read_check(RegionPlic, PlicClaimBase + 0, 32'd5, 1'b0);
      irq_sources_i = 8'h00;
      bus_write(RegionPlic, PlicClaimBase + 0, 32'd5, 1'b0);
      bus_write(RegionPlic, PlicClaimBase + 0, 32'd2, 1'b0);
      bus_read_check(RegionPlic, PlicPendingIdx, 32'h0, 1'b0);
      bus_read_check(RegionPlic, PlicClaimBase + 0, 32'd0, 1'b0);
   endtask

   task automatic back_to_back_reads();
      periph_addr_t addrs [5];
      logic [31:0]  exp_data [5];
      logic         exp_err [5];
      addrs[0] = make_addr(RegionGpio, GpioLedIdx);
      exp_data[0] = {24'h0, led_shadow};
      exp_err[0] = 1'b0;
      addrs[1] = make_addr(RegionGpio, GpioSwitchIdx);
      exp_data[1] = {24'h0, dip_switches_i};
      exp_err[1] = 1'b0;
      addrs[2] = make_addr(4'd5, 10'd3);
      exp_data[2] = ErrorRdata;
      exp_err[2] = 1'b1;
      addrs[3] = make_addr(RegionPlic, PlicPrioBase + 5);
      exp_data[3] = 32'd6;
      exp_err[3] = 1'b0;
      addrs[4] = make_addr(RegionPlic, PlicThresholdBase + 1);
      exp_data[4] = 32'd0;
      exp_err[4] = 1'b0;
      for (int i = 0; i < 5; i++) begin
         req_i  = 1'b1;
         we_i   = 1'b0;
         addr_i = addrs[i];
         @(negedge clk_i);
         if (rsp_valid_o !== 1'b1) report_mismatch("rsp_valid_o", rsp_valid_o, 1);
         if (rdata_o !== exp_data[i]) report_mismatch("rdata_o", rdata_o, exp_data[i]);
         if (err_o !== exp_err[i]) report_mismatch("err_o", err_o, exp_err[i]);
      end
      req_i = 1'b0;
      @(negedge clk_i);
      if (rsp_valid_o !== 1'b0) report_mismatch("rsp_valid_o", rsp_valid_o, 0);
   endtask

   initial begin
      reset_i        = 1'b1;
      req_i          = 1'b1; // Requests during reset must be ignored
      we_i           = 1'b0;
      addr_i         = '0;
      wdata_i        = '0;
      irq_sources_i  = '0;
      dip_switches_i = '0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      req_i   = 1'b0;
      @(negedge clk_i);

      reset_state();
      gpio_access();
      unmapped_access();
      priority_threshold();
      claim_complete();
      back_to_back_reads();

      $display("Errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
               value_errors, timeouts, periph_subsys_i.i_assertions.fail_count);
      if (value_errors == 0 && timeouts == 0 && periph_subsys_i.i_assertions.fail_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== periph_subsys.f ====
src/periph_pkg.sv
src/periph_addr_decode.sv
src/periph_gpio.sv
src/periph_plic.sv
src/periph_subsys.sv
tb/periph_subsys_assertions.sv
tb/tb_periph_subsys.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - src/periph_pkg.sv
  - src/periph_addr_decode.sv
  - src/periph_gpio.sv
  - src/periph_plic.sv
  - src/periph_subsys.sv
  - target: test
    files:
      - tb/periph_subsys_assertions.sv
      - tb/tb_periph_subsys.sv
